/* mipsIsaPkg.sv */
package mipsIsaPkg;

    // Instruction symbols, numeric order is visible outside the core
    typedef enum logic [5:0] {
        NOP, ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV, JALR, JR,
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, J, JAL
    } instrSym;

    // Major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcodeE;

    // Function codes of SPECIAL words, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } functE;

    // REGIMM selects the branch through the rt field
    localparam logic [4:0] RT_BLTZ = 5'd0;
    localparam logic [4:0] RT_BGEZ = 5'd1;

endpackage

/* pipePkg.sv */
package pipePkg;

    import mipsIsaPkg::*;

    // Decode stage output, fields of the raw word plus its symbol
    typedef struct packed {
        instrSym     sym;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [25:0] jmpAddr;
    } decodedInstr;

    // Operand stage output
    typedef struct packed {
        instrSym     sym;
        logic [31:0] srcA;
        // Register rt or the extended immediate
        logic [31:0] srcB;
        logic [4:0]  shamt;
        logic [4:0]  writeReg;
        logic        writeEn;
    } operandRec;

    // Retire record, also the writeback request
    typedef struct packed {
        instrSym     sym;
        logic        writeEn;
        logic [4:0]  writeReg;
        logic [31:0] result;
    } retireRec;

endpackage

/* Decoder.sv */
`timescale 1ns/1ns

module Decoder
    import mipsIsaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        inValid,
    output logic        inReady,
    input  logic [31:0] inWord,
    output logic        decValid,
    input  logic        decReady,
    output decodedInstr decData
);

    decodedInstr decoded;
    opcodeE      opcode;

    // SPECIAL words by funct
    function automatic instrSym decodeSpecial(input functE funct);
        case (funct)
            FN_ADD:  decodeSpecial = ADD;
            FN_SUB:  decodeSpecial = SUB;
            FN_ADDU: decodeSpecial = ADDU;
            FN_SUBU: decodeSpecial = SUBU;
            FN_AND:  decodeSpecial = AND;
            FN_OR:   decodeSpecial = OR;
            FN_XOR:  decodeSpecial = XOR;
            FN_NOR:  decodeSpecial = NOR;
            FN_SLT:  decodeSpecial = SLT;
            FN_SLTU: decodeSpecial = SLTU;
            FN_SLL:  decodeSpecial = SLL;
            FN_SLLV: decodeSpecial = SLLV;
            FN_SRL:  decodeSpecial = SRL;
            FN_SRLV: decodeSpecial = SRLV;
            FN_SRA:  decodeSpecial = SRA;
            FN_SRAV: decodeSpecial = SRAV;
            FN_JALR: decodeSpecial = JALR;
            FN_JR:   decodeSpecial = JR;
            default: decodeSpecial = NOP;
        endcase
    endfunction

    function automatic instrSym decodeRegimm(input logic [4:0] rt);
        if (rt == RT_BGEZ)
        begin
            decodeRegimm = BGEZ;
        end
        else if (rt == RT_BLTZ)
        begin
            decodeRegimm = BLTZ;
        end
        else
        begin
            decodeRegimm = NOP;
        end
    endfunction

    // Immediate, memory, branch and jump forms
    function automatic instrSym decodeOther(input opcodeE op);
        case (op)
            OP_ADDI:  decodeOther = ADDI;
            OP_ADDIU: decodeOther = ADDIU;
            OP_ANDI:  decodeOther = ANDI;
            OP_ORI:   decodeOther = ORI;
            OP_XORI:  decodeOther = XORI;
            OP_LUI:   decodeOther = LUI;
            OP_SLTI:  decodeOther = SLTI;
            OP_SLTIU: decodeOther = SLTIU;
            OP_LW:    decodeOther = LW;
            OP_LH:    decodeOther = LH;
            OP_LHU:   decodeOther = LHU;
            OP_LB:    decodeOther = LB;
            OP_LBU:   decodeOther = LBU;
            OP_SW:    decodeOther = SW;
            OP_SH:    decodeOther = SH;
            OP_SB:    decodeOther = SB;
            OP_BEQ:   decodeOther = BEQ;
            OP_BNE:   decodeOther = BNE;
            OP_BLEZ:  decodeOther = BLEZ;
            OP_BGTZ:  decodeOther = BGTZ;
            OP_J:     decodeOther = J;
            OP_JAL:   decodeOther = JAL;
            default:  decodeOther = NOP;
        endcase
    endfunction

    assign opcode = opcodeE'(inWord[31:26]);

    always_comb
    begin
        decoded.rs      = inWord[25:21];
        decoded.rt      = inWord[20:16];
        decoded.rd      = inWord[15:11];
        decoded.shamt   = inWord[10:6];
        decoded.imm     = inWord[15:0];
        decoded.jmpAddr = inWord[25:0];
        if (opcode == OP_REGIMM)
        begin
            decoded.sym = decodeRegimm(inWord[20:16]);
        end
        else if (opcode == OP_SPECIAL)
        begin
            decoded.sym = decodeSpecial(functE'(inWord[5:0]));
        end
        else
        begin
            decoded.sym = decodeOther(opcode);
        end
    end

    // Single slot is free when empty or draining this cycle
    assign inReady = !decValid || decReady;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            decValid <= 1'b0;
        end
        else if (inValid && inReady)
        begin
            decValid <= 1'b1;
        end
        else if (decReady)
        begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
        begin
            decData <= decoded;
        end
    end

    inHoldStable: assert property (@(posedge clk) disable iff (!arstN)
        inValid && !inReady |=> inValid && $stable(inWord))
        else $error("Input word changed before it was accepted");

endmodule

/* OperandFetch.sv */
`timescale 1ns/1ns

module OperandFetch
    import mipsIsaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        decValid,
    output logic        decReady,
    input  decodedInstr decData,
    output logic        opValid,
    input  logic        opReady,
    output operandRec   opData,
    input  logic        wbEn,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    input  logic        pendValid,
    input  logic [4:0]  pendReg
);

    logic [31:0] regs [32];
    decodedInstr slot;
    logic        slotValid;
    logic        isRType;
    logic        isImm;
    logic        fixedShift;
    logic        usesRs;
    logic        usesRt;
    logic        hazard;
    logic [4:0]  destReg;
    logic [31:0] immExt;

    function automatic logic [31:0] readReg(input logic [4:0] idx);
        readReg = (idx == 5'd0) ? 32'd0 : regs[idx];
    endfunction

    // Symbol ranges follow the enum order
    always_comb
    begin
        isRType    = (slot.sym >= ADD) && (slot.sym <= SRAV);
        isImm      = (slot.sym >= ADDI) && (slot.sym <= SLTIU);
        fixedShift = (slot.sym == SLL) || (slot.sym == SRL) || (slot.sym == SRA);
        usesRs     = (isRType && !fixedShift) || (isImm && slot.sym != LUI);
        usesRt     = isRType;
        destReg    = isRType ? slot.rd : slot.rt;
        if ((slot.sym == ANDI) || (slot.sym == ORI) || (slot.sym == XORI))
        begin
            immExt = {16'd0, slot.imm};
        end
        else
        begin
            immExt = {{16{slot.imm[15]}}, slot.imm};
        end
    end

    // Wait for an older writer still sitting in Execute
    assign hazard = pendValid &&
        ((usesRs && pendReg == slot.rs) || (usesRt && pendReg == slot.rt));

    always_comb
    begin
        opData.sym      = slot.sym;
        opData.srcA     = usesRs ? readReg(slot.rs) : 32'd0;
        opData.srcB     = isImm ? immExt : (usesRt ? readReg(slot.rt) : 32'd0);
        opData.shamt    = slot.shamt;
        opData.writeReg = destReg;
        opData.writeEn  = (isRType || isImm) && (destReg != 5'd0);
    end

    assign opValid  = slotValid && !hazard;
    assign decReady = !slotValid || (opValid && opReady);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            slotValid <= 1'b0;
        end
        else if (decValid && decReady)
        begin
            slotValid <= 1'b1;
        end
        else if (opValid && opReady)
        begin
            slotValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (decValid && decReady)
        begin
            slot <= decData;
        end
    end

    // Register file, all zero after reset
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= 32'd0;
            end
        end
        else if (wbEn && wbReg != 5'd0)
        begin
            regs[wbReg] <= wbData;
        end
    end

    noZeroWrite: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |-> wbReg != 5'd0)
        else $error("Writeback aimed at register 0");

endmodule

/* Execute.sv */
`timescale 1ns/1ns

module Execute
    import mipsIsaPkg::*;
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       opValid,
    output logic       opReady,
    input  operandRec  opData,
    output logic       outValid,
    input  logic       outReady,
    output retireRec   outData,
    output logic       pendValid,
    output logic [4:0] pendReg
);

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA
    } aluOpE;

    aluOpE       aluOp;
    logic        varShift;
    logic [4:0]  shiftAmt;
    logic [31:0] aluResult;

    // ADD and ADDI wrap without an overflow trap
    function automatic aluOpE aluOpOf(input instrSym sym);
        case (sym)
            ADD, ADDU, ADDI, ADDIU: aluOpOf = ALU_ADD;
            SUB, SUBU:              aluOpOf = ALU_SUB;
            AND, ANDI:              aluOpOf = ALU_AND;
            OR, ORI:                aluOpOf = ALU_OR;
            XOR, XORI:              aluOpOf = ALU_XOR;
            NOR:                    aluOpOf = ALU_NOR;
            SLT, SLTI:              aluOpOf = ALU_SLT;
            SLTU, SLTIU:            aluOpOf = ALU_SLTU;
            LUI:                    aluOpOf = ALU_LUI;
            SLL, SLLV:              aluOpOf = ALU_SLL;
            SRL, SRLV:              aluOpOf = ALU_SRL;
            SRA, SRAV:              aluOpOf = ALU_SRA;
            default:                aluOpOf = ALU_NONE;
        endcase
    endfunction

    always_comb
    begin
        aluOp    = aluOpOf(opData.sym);
        varShift = (opData.sym == SLLV) || (opData.sym == SRLV) || (opData.sym == SRAV);
        shiftAmt = varShift ? opData.srcA[4:0] : opData.shamt;
        case (aluOp)
            ALU_ADD:  aluResult = opData.srcA + opData.srcB;
            ALU_SUB:  aluResult = opData.srcA - opData.srcB;
            ALU_AND:  aluResult = opData.srcA & opData.srcB;
            ALU_OR:   aluResult = opData.srcA | opData.srcB;
            ALU_XOR:  aluResult = opData.srcA ^ opData.srcB;
            ALU_NOR:  aluResult = ~(opData.srcA | opData.srcB);
            ALU_SLT:  aluResult = {31'd0, $signed(opData.srcA) < $signed(opData.srcB)};
            ALU_SLTU: aluResult = {31'd0, opData.srcA < opData.srcB};
            ALU_LUI:  aluResult = {opData.srcB[15:0], 16'd0};
            ALU_SLL:  aluResult = opData.srcB << shiftAmt;
            ALU_SRL:  aluResult = opData.srcB >> shiftAmt;
            ALU_SRA:  aluResult = $unsigned($signed(opData.srcB) >>> shiftAmt);
            default:  aluResult = 32'd0;
        endcase
    end

    assign opReady = !outValid || outReady;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            outValid <= 1'b0;
        end
        else if (opValid && opReady)
        begin
            outValid <= 1'b1;
        end
        else if (outReady)
        begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (opValid && opReady)
        begin
            outData.sym      <= opData.sym;
            outData.writeEn  <= opData.writeEn;
            outData.writeReg <= opData.writeReg;
            outData.result   <= aluResult;
        end
    end

    // Only a held writing record blocks the operand stage
    assign pendValid = outValid && outData.writeEn;
    assign pendReg   = outData.writeReg;

    opHeld: assert property (@(posedge clk) disable iff (!arstN)
        opValid && !opReady |=> opValid && $stable(opData))
        else $error("Operand record changed while Execute was full");

endmodule

/* MipsCore.sv */
`timescale 1ns/1ns

module MipsCore
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        inValid,
    output logic        inReady,
    input  logic [31:0] inWord,
    output logic        outValid,
    input  logic        outReady,
    output retireRec    outData
);

    logic        decValid;
    logic        decReady;
    decodedInstr decData;
    logic        opValid;
    logic        opReady;
    operandRec   opData;
    logic        pendValid;
    logic [4:0]  pendReg;
    logic        wbEn;

    Decoder decoder (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inWord   (inWord),
        .decValid (decValid),
        .decReady (decReady),
        .decData  (decData)
    );

    OperandFetch operandFetch (
        .clk       (clk),
        .arstN     (arstN),
        .decValid  (decValid),
        .decReady  (decReady),
        .decData   (decData),
        .opValid   (opValid),
        .opReady   (opReady),
        .opData    (opData),
        .wbEn      (wbEn),
        .wbReg     (outData.writeReg),
        .wbData    (outData.result),
        .pendValid (pendValid),
        .pendReg   (pendReg)
    );

    Execute execute (
        .clk       (clk),
        .arstN     (arstN),
        .opValid   (opValid),
        .opReady   (opReady),
        .opData    (opData),
        .outValid  (outValid),
        .outReady  (outReady),
        .outData   (outData),
        .pendValid (pendValid),
        .pendReg   (pendReg)
    );

    // Register file updates on the retire transfer
    assign wbEn = outValid && outReady && outData.writeEn;

endmodule

/* RetireChecker.sv */
`timescale 1ns/1ns

module RetireChecker
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     outValid,
    input  logic     outReady,
    input  retireRec outData,
    output logic     done,
    output int       passCount,
    output int       failCount
);

    logic [5:0]  expSym [$];
    logic        expWe [$];
    logic [4:0]  expReg [$];
    logic [31:0] expResult [$];
    int          testNum;

    task automatic loadExpected();
        int          fd;
        int          n;
        string       line;
        logic [31:0] word;
        logic [5:0]  sym;
        logic        we;
        logic [4:0]  wrReg;
        logic [31:0] result;
        fd = $fopen("stimulus_input.txt", "r");
        if (fd == 0)
        begin
            $display("Checker cannot open stimulus_input.txt");
            failCount++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#")
                begin
                    if ($sscanf(line, "%h %d %d %d %h", word, sym, we, wrReg, result) == 5)
                    begin
                        expSym.push_back(sym);
                        expWe.push_back(we);
                        expReg.push_back(wrReg);
                        expResult.push_back(result);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("Fail t=%0t %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic checkRecord();
        int idx;
        bit good;
        good = 1'b1;
        idx  = testNum;
        testNum++;
        if (idx >= expSym.size())
        begin
            $display("Test %0d failed: a retire record came after the last expected one",
                testNum);
            failCount++;
        end
        else
        begin
            if (outData.sym !== expSym[idx])
            begin
                reportMismatch("outData.sym", 32'(outData.sym), 32'(expSym[idx]));
                good = 1'b0;
            end
            if (outData.writeEn !== expWe[idx])
            begin
                reportMismatch("outData.writeEn", 32'(outData.writeEn), 32'(expWe[idx]));
                good = 1'b0;
            end
            // writeReg carries no meaning without writeEn
            if (expWe[idx] && outData.writeReg !== expReg[idx])
            begin
                reportMismatch("outData.writeReg", 32'(outData.writeReg), 32'(expReg[idx]));
                good = 1'b0;
            end
            if (outData.result !== expResult[idx])
            begin
                reportMismatch("outData.result", outData.result, expResult[idx]);
                good = 1'b0;
            end
            if (good)
            begin
                $display("Test %0d passed, sym %0d", testNum, expSym[idx]);
                passCount++;
            end
            else
            begin
                $display("Test %0d failed", testNum);
                failCount++;
            end
            if (testNum == expSym.size())
            begin
                done = 1'b1;
            end
        end
    endtask

    // A handshake seen between edges transfers at the next rising edge
    initial
    begin
        done      = 1'b0;
        passCount = 0;
        failCount = 0;
        testNum   = 0;
        loadExpected();
        if (expSym.size() == 0)
        begin
            $display("No expected retire records were read");
            failCount++;
            done = 1'b1;
        end
        forever
        begin
            @(negedge clk);
            #1;
            if (arstN && outValid && outReady)
            begin
                checkRecord();
            end
        end
    end

endmodule

/* tb_MipsCore.sv */
`timescale 1ns/1ns

module tb_MipsCore
    import pipePkg::*;
();

    localparam int ReadyTimeout = 200;
    localparam int DrainTimeout = 2000;

    logic        clk;
    logic        arstN;
    logic        inValid;
    logic        inReady;
    logic [31:0] inWord;
    logic        outValid;
    logic        outReady;
    retireRec    outData;
    logic        checkDone;
    int          passCount;
    int          failCount;
    int          topErrors;
    int          topPasses;
    bit          resetDone;
    bit          timedOut;
    logic [31:0] words [$];

    MipsCore dut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inWord   (inWord),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    RetireChecker retireChecker (
        .clk       (clk),
        .arstN     (arstN),
        .outValid  (outValid),
        .outReady  (outReady),
        .outData   (outData),
        .done      (checkDone),
        .passCount (passCount),
        .failCount (failCount)
    );

    always #2 clk = ~clk;

    // Random back-pressure stalls about one cycle in four
    always @(negedge clk)
    begin
        if (resetDone)
        begin
            outReady = ($urandom % 4) != 0;
        end
    end

    // Only the machine words are needed here
    task automatic loadWords();
        int          fd;
        int          n;
        string       line;
        logic [31:0] word;
        fd = $fopen("stimulus_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open stimulus_input.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#")
                begin
                    if ($sscanf(line, "%h", word) == 1)
                    begin
                        words.push_back(word);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds the word until inReady is seen high between edges
    task automatic sendWord(input logic [31:0] word, output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        inValid = 1'b1;
        inWord  = word;
        #1;
        while (!inReady && waited < ReadyTimeout)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        ok = inReady;
    endtask

    initial
    begin
        bit ok;
        int waited;
        clk       = 1'b0;
        arstN     = 1'b0;
        inValid   = 1'b0;
        inWord    = 32'd0;
        outReady  = 1'b0;
        resetDone = 1'b0;
        timedOut  = 1'b0;
        topErrors = 0;
        topPasses = 0;
        void'($urandom(32'hcbf819d6));
        loadWords();
        if (words.size() == 0)
        begin
            $display("No instruction words were read from the stimulus file");
            topErrors++;
        end

        repeat (16) @(posedge clk);
        resetDone = 1'b1;
        @(negedge clk);
        arstN     = 1'b1;
        #1;
        if (inReady !== 1'b1 || outValid !== 1'b0)
        begin
            if (inReady !== 1'b1)
            begin
                $display("Fail t=%0t inReady got %b expected 1", $time, inReady);
            end
            if (outValid !== 1'b0)
            begin
                $display("Fail t=%0t outValid got %b expected 0", $time, outValid);
            end
            $display("Reset check failed");
            topErrors++;
        end
        else
        begin
            $display("Reset check passed");
            topPasses++;
        end

        foreach (words[i])
        begin
            if (!timedOut)
            begin
                sendWord(words[i], ok);
                if (!ok)
                begin
                    $display("Timeout: inReady stayed low for %0d cycles at word %0d",
                        ReadyTimeout, i);
                    timedOut = 1'b1;
                end
            end
        end

        if (!timedOut)
        begin
            @(negedge clk);
            inValid = 1'b0;
            waited = 0;
            while (!checkDone && waited < DrainTimeout)
            begin
                @(negedge clk);
                waited++;
            end
            if (!checkDone)
            begin
                $display("Timeout: not every expected retire record arrived");
                timedOut = 1'b1;
            end
        end
        // Room for a stray extra record to show up
        repeat (10) @(negedge clk);

        $display("Tests: %0d passed, %0d failed", passCount + topPasses, failCount + topErrors);
        if (timedOut || topErrors != 0 || failCount != 0)
        begin
            $display(">>> FAIL");
        end
        else
        begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

/* stimulus_input.txt */
# word(hex) sym(dec) writeEn(dec) writeReg(dec) result(hex)
# writeReg is 0 where writeEn is 0, sym uses the instrSym codes
00430821 3 1 1 00000000
24011234 20 1 1 00001234
2002fffb 19 1 2 fffffffb
00221820 1 1 3 0000122f
00222022 2 1 4 00001239
00412823 4 1 5 ffffedc7
00223024 5 1 6 00001230
00223825 6 1 7 ffffffff
00224026 7 1 8 ffffedcf
00224827 8 1 9 00000000
0041502a 9 1 10 00000001
0041582b 10 1 11 00000000
00016100 11 1 12 00012340
00026843 15 1 13 fffffffd
00027702 13 1 14 0000000f
01c17804 12 1 15 091a0000
01c28007 16 1 16 ffffffff
3051f0f0 21 1 17 0000f0f0
34328000 22 1 18 00009234
3a53ffff 23 1 19 00006dcb
3c14abcd 24 1 20 abcd0000
2855fffc 25 1 21 00000001
2c36ffff 26 1 22 00000001
24200005 20 0 0 00001239
0000b825 6 1 23 00000000
8c380008 27 0 0 00000000
ac220004 32 0 0 00000000
10220010 35 0 0 00000000
04210003 39 0 0 00000000
04400003 40 0 0 00000000
08000100 41 0 0 00000000
00200008 18 0 0 00000000
0020f809 17 0 0 00000000
fc000000 0 0 0 00000000
04050000 0 0 0 00000000
00000000 11 0 0 00000000

/* files.f */
mipsIsaPkg.sv
pipePkg.sv
Decoder.sv
OperandFetch.sv
Execute.sv
MipsCore.sv
RetireChecker.sv
tb_MipsCore.sv

/* run.sh */
#!/bin/sh
# Build and run the MipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
    -f files.f --top-module tb_MipsCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_MipsCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
exit 1
